// ==== verilog/bus_pkg.sv ====
// Single-beat bus types only; 16-bit byte address, word aligned, no IDs, bursts or protection
package bus_pkg;

   // ******************************
   // Bus widths
   // ******************************
   localparam int ADDR_W  = 16;
   localparam int DATA_W  = 32;
   localparam int STRB_W  = DATA_W / 8;
   // Word address, byte offset dropped
   localparam int WADDR_W = ADDR_W - 2;

   // ******************************
   // Response codes
   // ******************************
   typedef logic [1:0] t_resp;

   localparam t_resp RESP_OKAY   = 2'b00;
   localparam t_resp RESP_SLVERR = 2'b10;

   // Request as seen past the AXI front
   typedef struct packed {
      logic [WADDR_W-1:0] addr;
      logic [DATA_W-1:0]  wdata;
      logic [STRB_W-1:0]  strb;
      logic               write;
   } t_bus_req;

   // Response heading back to the AXI side
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      t_resp             resp;
      logic              write;
   } t_bus_rsp;

endpackage

// ==== verilog/soc_map_pkg.sv ====
// Address map for a 16-bit byte address; only the GPIO window decodes, anything else errors
package soc_map_pkg;

   // GPIO window, 256 bytes at the bottom of the map
   localparam logic [15:0] GPIO_BASE   = 16'h0000;
   localparam int          GPIO_SPAN_W = 8;

   // ******************************
   // GPIO register byte offsets
   // ******************************
   localparam logic [GPIO_SPAN_W-1:0] REG_OUT      = 8'h00;
   localparam logic [GPIO_SPAN_W-1:0] REG_DIR      = 8'h04;
   localparam logic [GPIO_SPAN_W-1:0] REG_IN       = 8'h08;
   localparam logic [GPIO_SPAN_W-1:0] REG_IRQ_MASK = 8'h0C;
   localparam logic [GPIO_SPAN_W-1:0] REG_IRQ_STAT = 8'h10;
   localparam logic [GPIO_SPAN_W-1:0] REG_ID       = 8'h14;

   // Read-only block identifier
   localparam logic [31:0] GPIO_ID = 32'h6770_0001;

endpackage

// ==== verilog/wb_if.sv ====
// Classic single Wishbone cycle only; no err, rty, cti or bte, one slave per interface
`timescale 1ns/1ns

interface wb_if #(
   parameter int ADR_W = 14,
   parameter int DAT_W = 32
);

   logic [ADR_W-1:0]   adr;
   logic [DAT_W-1:0]   dat_w;
   logic [DAT_W/8-1:0] sel;
   logic               we;
   logic               cyc;
   logic               stb;
   logic [DAT_W-1:0]   dat_r;
   logic               ack;

   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack
   );

endinterface

// ==== verilog/pipe_fifo.sv ====
// FIFO_DEPTH must be a power of two, 2 or more; a full queue still accepts on a pop
`timescale 1ns/1ns

module pipe_fifo #(
   parameter int  FIFO_DEPTH = 2,
   parameter type t_payload  = logic [31:0]
) (
   input  logic     i_clk,
   input  logic     i_reset,
   input  logic     i_valid,
   output logic     o_ready,
   input  t_payload i_data,
   output logic     o_valid,
   input  logic     i_ready,
   output t_payload o_data
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(FIFO_DEPTH);

   t_payload         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             push;
   logic             pop;

   assign o_valid = (count != '0);
   assign o_ready = (count != FULL_CNT) || i_ready;
   assign push    = i_valid && o_ready;
   assign pop     = o_valid && i_ready;
   assign o_data  = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // Pointers wrap naturally
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== verilog/axi_req_front.sv ====
// Single-beat AXI writes need address and data valid together; writes beat reads in a tie
`timescale 1ns/1ns

module axi_req_front
   import bus_pkg::*;
#(
   parameter int FIFO_DEPTH = 2
) (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_awvalid,
   output logic              o_awready,
   input  logic [ADDR_W-1:0] i_awaddr,
   input  logic              i_wvalid,
   output logic              o_wready,
   input  logic [DATA_W-1:0] i_wdata,
   input  logic [STRB_W-1:0] i_wstrb,
   input  logic              i_arvalid,
   output logic              o_arready,
   input  logic [ADDR_W-1:0] i_araddr,
   output logic              o_req_valid,
   input  logic              i_req_ready,
   output t_bus_req          o_req
);

   logic     active_q;
   logic     q_ready;
   logic     wr_pend;
   logic     wr_go;
   logic     rd_go;
   t_bus_req req_in;

   // Channels stay closed until the first cycle out of reset
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         active_q <= 1'b0;
      end else begin
         active_q <= 1'b1;
      end
   end

   // ******************************
   // Handshake join and priority
   // ******************************
   assign wr_pend = i_awvalid && i_wvalid;
   assign wr_go   = active_q && q_ready && wr_pend;
   assign rd_go   = active_q && q_ready && i_arvalid && !wr_pend;

   assign o_awready = wr_go;
   assign o_wready  = wr_go;
   assign o_arready = rd_go;

   always_comb begin
      req_in.addr  = wr_pend ? i_awaddr[ADDR_W-1:2] : i_araddr[ADDR_W-1:2];
      req_in.wdata = i_wdata;
      req_in.strb  = wr_pend ? i_wstrb : '0;
      req_in.write = wr_pend;
   end

   pipe_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .t_payload  (t_bus_req)
   ) u_req_fifo (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (wr_go || rd_go),
      .o_ready (q_ready),
      .i_data  (req_in),
      .o_valid (o_req_valid),
      .i_ready (i_req_ready),
      .o_data  (o_req)
   );

endmodule

// ==== verilog/wb_master.sv ====
// One Wishbone cycle at a time; a request is taken only when its response is sure to fit
`timescale 1ns/1ns

module wb_master
   import bus_pkg::*;
   import soc_map_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_reset,
   input  logic     i_req_valid,
   output logic     o_req_ready,
   input  t_bus_req i_req,
   output logic     o_rsp_valid,
   input  logic     i_rsp_ready,
   output t_bus_rsp o_rsp,
   wb_if.master     wb
);

   typedef enum logic {
      ST_IDLE,
      ST_CYCLE
   } t_state;

   t_state             state_q;
   logic               err_q;
   logic               pop;
   logic               in_window;
   logic               done;
   logic [WADDR_W-1:0] adr_q;
   logic [DATA_W-1:0]  dat_q;
   logic [STRB_W-1:0]  sel_q;
   logic               we_q;

   // Upper word address bits against the window base
   assign in_window = (i_req.addr[WADDR_W-1:GPIO_SPAN_W-2] ==
                       GPIO_BASE[ADDR_W-1:GPIO_SPAN_W]);

   assign o_req_ready = (state_q == ST_IDLE) && i_rsp_ready;
   assign pop         = o_req_ready && i_req_valid;
   assign done        = (state_q == ST_CYCLE) && (err_q || wb.ack);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state_q <= ST_IDLE;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (pop) begin
                  state_q <= ST_CYCLE;
                  err_q   <= !in_window;
               end
            end
            ST_CYCLE: begin
               if (done) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (pop) begin
         adr_q <= i_req.addr;
         dat_q <= i_req.wdata;
         sel_q <= i_req.strb;
         we_q  <= i_req.write;
      end
   end

   // ******************************
   // Wishbone drive and response
   // ******************************
   assign wb.adr   = adr_q;
   assign wb.dat_w = dat_q;
   assign wb.sel   = sel_q;
   assign wb.we    = we_q;
   assign wb.cyc   = (state_q == ST_CYCLE) && !err_q;
   assign wb.stb   = (state_q == ST_CYCLE) && !err_q;

   assign o_rsp_valid = done;

   always_comb begin
      o_rsp.rdata = (err_q || we_q) ? '0 : wb.dat_r;
      o_rsp.resp  = err_q ? RESP_SLVERR : RESP_OKAY;
      o_rsp.write = we_q;
   end

endmodule

// ==== verilog/gpio_regs.sv ====
// Ack one cycle after stb; GPIO_W of 1 to 32 pads, upper data bits read zero and are ignored
`timescale 1ns/1ns

module gpio_regs
   import bus_pkg::*;
   import soc_map_pkg::*;
#(
   parameter int GPIO_W = 32
) (
   input  logic            i_clk,
   input  logic            i_reset,
   wb_if.slave             wb,
   inout  wire [GPIO_W-1:0] io_gpio,
   output logic            o_irq
);

   logic [GPIO_W-1:0]      out_q;
   logic [GPIO_W-1:0]      dir_q;
   logic [GPIO_W-1:0]      mask_q;
   logic [GPIO_W-1:0]      stat_q;
   logic [GPIO_W-1:0]      sync1_q;
   logic [GPIO_W-1:0]      sync2_q;
   logic [GPIO_W-1:0]      sync_d_q;
   logic [GPIO_W-1:0]      wmask;
   logic [GPIO_W-1:0]      wbits;
   logic [GPIO_W-1:0]      clr;
   logic [GPIO_W-1:0]      rise;
   logic [GPIO_SPAN_W-1:0] offset;
   logic [DATA_W-1:0]      rd_mux;
   logic [DATA_W-1:0]      rd_q;
   logic                   ack_q;
   logic                   access;
   logic                   wr_en;
   logic                   irq_q;

   assign offset = {wb.adr[GPIO_SPAN_W-3:0], 2'b00};
   assign access = wb.cyc && wb.stb && !ack_q;
   assign wr_en  = access && wb.we;

   // Per-bit enable from the byte strobes
   always_comb begin
      for (int i = 0; i < GPIO_W; i++) begin
         wmask[i] = wb.sel[i/8];
      end
   end

   assign wbits = wb.dat_w[GPIO_W-1:0] & wmask;
   assign clr   = (wr_en && offset == REG_IRQ_STAT) ? wbits : '0;

   // ******************************
   // Pads and input synchronizer
   // ******************************
   for (genvar g = 0; g < GPIO_W; g++) begin : g_pad
      assign io_gpio[g] = dir_q[g] ? out_q[g] : 1'bz;
   end

   always_ff @(posedge i_clk) begin
      sync1_q  <= io_gpio;
      sync2_q  <= sync1_q;
      sync_d_q <= sync2_q;
   end

   assign rise = sync2_q & ~sync_d_q;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         out_q  <= '0;
         dir_q  <= '0;
         mask_q <= '0;
         stat_q <= '0;
         ack_q  <= 1'b0;
         irq_q  <= 1'b0;
      end else begin
         ack_q  <= access;
         irq_q  <= |(stat_q & mask_q);
         // New edges win over a clear in the same cycle
         stat_q <= (stat_q & ~clr) | rise;
         if (wr_en && offset == REG_OUT) begin
            out_q <= (out_q & ~wmask) | wbits;
         end
         if (wr_en && offset == REG_DIR) begin
            dir_q <= (dir_q & ~wmask) | wbits;
         end
         if (wr_en && offset == REG_IRQ_MASK) begin
            mask_q <= (mask_q & ~wmask) | wbits;
         end
      end
   end

   always_comb begin
      case (offset)
         REG_OUT:      rd_mux = DATA_W'(out_q);
         REG_DIR:      rd_mux = DATA_W'(dir_q);
         REG_IN:       rd_mux = DATA_W'(sync2_q);
         REG_IRQ_MASK: rd_mux = DATA_W'(mask_q);
         REG_IRQ_STAT: rd_mux = DATA_W'(stat_q);
         REG_ID:       rd_mux = GPIO_ID;
         default:      rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (access) begin
         rd_q <= rd_mux;
      end
   end

   assign wb.dat_r = rd_q;
   assign wb.ack   = ack_q;
   assign o_irq    = irq_q;

endmodule

// ==== verilog/axi_resp_back.sv ====
// Responses leave strictly in request order; a stalled channel blocks the other one
`timescale 1ns/1ns

module axi_resp_back
   import bus_pkg::*;
#(
   parameter int FIFO_DEPTH = 2
) (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_rsp_valid,
   output logic              o_rsp_ready,
   input  t_bus_rsp          i_rsp,
   output logic              o_bvalid,
   input  logic              i_bready,
   output t_resp             o_bresp,
   output logic              o_rvalid,
   input  logic              i_rready,
   output logic [DATA_W-1:0] o_rdata,
   output t_resp             o_rresp
);

   logic     head_valid;
   logic     head_pop;
   t_bus_rsp head;

   pipe_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .t_payload  (t_bus_rsp)
   ) u_rsp_fifo (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (i_rsp_valid),
      .o_ready (o_rsp_ready),
      .i_data  (i_rsp),
      .o_valid (head_valid),
      .i_ready (head_pop),
      .o_data  (head)
   );

   // Steer the head entry by its write flag
   assign head_pop = head.write ? i_bready : i_rready;
   assign o_bvalid = head_valid && head.write;
   assign o_rvalid = head_valid && !head.write;
   assign o_bresp  = head.resp;
   assign o_rresp  = head.resp;
   assign o_rdata  = head.rdata;

endmodule

// ==== verilog/io_bridge_top.sv ====
// AXI-lite style single-beat port to one GPIO block; only the low 256 bytes are mapped
`timescale 1ns/1ns

module io_bridge_top
   import bus_pkg::*;
#(
   parameter int FIFO_DEPTH = 2,
   parameter int GPIO_W     = 32
) (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_awvalid,
   output logic              o_awready,
   input  logic [ADDR_W-1:0] i_awaddr,
   input  logic              i_wvalid,
   output logic              o_wready,
   input  logic [DATA_W-1:0] i_wdata,
   input  logic [STRB_W-1:0] i_wstrb,
   output logic              o_bvalid,
   input  logic              i_bready,
   output t_resp             o_bresp,
   input  logic              i_arvalid,
   output logic              o_arready,
   input  logic [ADDR_W-1:0] i_araddr,
   output logic              o_rvalid,
   input  logic              i_rready,
   output logic [DATA_W-1:0] o_rdata,
   output t_resp             o_rresp,
   inout  wire [GPIO_W-1:0]  io_gpio,
   output logic              o_irq
);

   logic     req_valid;
   logic     req_ready;
   t_bus_req req;
   logic     rsp_valid;
   logic     rsp_ready;
   t_bus_rsp rsp;

   wb_if #(
      .ADR_W (WADDR_W),
      .DAT_W (DATA_W)
   ) u_wb ();

   axi_req_front #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_axi_req_front (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_awvalid   (i_awvalid),
      .o_awready   (o_awready),
      .i_awaddr    (i_awaddr),
      .i_wvalid    (i_wvalid),
      .o_wready    (o_wready),
      .i_wdata     (i_wdata),
      .i_wstrb     (i_wstrb),
      .i_arvalid   (i_arvalid),
      .o_arready   (o_arready),
      .i_araddr    (i_araddr),
      .o_req_valid (req_valid),
      .i_req_ready (req_ready),
      .o_req       (req)
   );

   wb_master u_wb_master (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_req_valid (req_valid),
      .o_req_ready (req_ready),
      .i_req       (req),
      .o_rsp_valid (rsp_valid),
      .i_rsp_ready (rsp_ready),
      .o_rsp       (rsp),
      .wb          (u_wb.master)
   );

   gpio_regs #(
      .GPIO_W (GPIO_W)
   ) u_gpio_regs (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .wb      (u_wb.slave),
      .io_gpio (io_gpio),
      .o_irq   (o_irq)
   );

   axi_resp_back #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_axi_resp_back (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_rsp_valid (rsp_valid),
      .o_rsp_ready (rsp_ready),
      .i_rsp       (rsp),
      .o_bvalid    (o_bvalid),
      .i_bready    (i_bready),
      .o_bresp     (o_bresp),
      .o_rvalid    (o_rvalid),
      .i_rready    (i_rready),
      .o_rdata     (o_rdata),
      .o_rresp     (o_rresp)
   );

endmodule

// ==== verif/tb_io_model.svh ====
// Included inside tb_io_bridge only; uses its bus signals, pad variables, abort_run and note_mismatch
`ifndef TB_IO_MODEL_SVH
`define TB_IO_MODEL_SVH

   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   localparam int          WAIT_MAX  = 200;

   logic [31:0] lfsr_state = 32'hd3d6_a575;

   // Expected GPIO register contents from reset onward
   logic [31:0] model_out  = '0;
   logic [31:0] model_dir  = '0;
   logic [31:0] model_mask = '0;
   logic [31:0] model_stat = '0;

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      end
      return r;
   endfunction

   // Word aligned with a nonzero high byte
   function automatic logic [15:0] unmapped_addr();
      logic [31:0] r;
      r = rand_bits(14);
      return {r[13:6] | 8'h01, r[5:0], 2'b00};
   endfunction

   function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
      return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
   endfunction

   // ******************************
   // Register model
   // ******************************
   function automatic t_resp model_write(input logic [15:0] addr, input logic [31:0] data,
                                         input logic [3:0] strb);
      logic [31:0] bm;
      bm = strobe_mask(strb);
      if (addr[15:8] != GPIO_BASE[15:8]) begin
         return RESP_SLVERR;
      end
      case (addr[7:0] & 8'hfc)
         REG_OUT:      model_out  = (model_out & ~bm) | (data & bm);
         REG_DIR:      model_dir  = (model_dir & ~bm) | (data & bm);
         REG_IRQ_MASK: model_mask = (model_mask & ~bm) | (data & bm);
         REG_IRQ_STAT: model_stat = model_stat & ~(data & bm);
         default:      ;
      endcase
      return RESP_OKAY;
   endfunction

   function automatic t_resp model_read(input logic [15:0] addr, output logic [31:0] data);
      data = '0;
      if (addr[15:8] != GPIO_BASE[15:8]) begin
         return RESP_SLVERR;
      end
      case (addr[7:0] & 8'hfc)
         REG_OUT:      data = model_out;
         REG_DIR:      data = model_dir;
         REG_IN:       data = (model_out & model_dir) | (pad_val & ~model_dir);
         REG_IRQ_MASK: data = model_mask;
         REG_IRQ_STAT: data = model_stat;
         REG_ID:       data = GPIO_ID;
         default:      data = '0;
      endcase
      return RESP_OKAY;
   endfunction

   // ******************************
   // Bus helpers
   // ******************************
   task automatic send_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      int cnt;
      @(posedge i_clk);
      i_awvalid <= 1'b1;
      i_awaddr  <= addr;
      i_wvalid  <= 1'b1;
      i_wdata   <= data;
      i_wstrb   <= strb;
      @(negedge i_clk);
      for (cnt = 0; !(o_awready || o_wready) && cnt < WAIT_MAX; cnt++) begin
         @(negedge i_clk);
      end
      if (!(o_awready || o_wready)) begin
         abort_run("write request was not accepted in time");
      end
      // Address and data readies rise together
      if (o_awready !== 1'b1) begin
         note_mismatch("o_awready", o_awready, 1'b1);
      end
      if (o_wready !== 1'b1) begin
         note_mismatch("o_wready", o_wready, 1'b1);
      end
      @(posedge i_clk);
      i_awvalid <= 1'b0;
      i_wvalid  <= 1'b0;
   endtask

   task automatic send_read(input logic [15:0] addr);
      int cnt;
      @(posedge i_clk);
      i_arvalid <= 1'b1;
      i_araddr  <= addr;
      @(negedge i_clk);
      for (cnt = 0; !o_arready && cnt < WAIT_MAX; cnt++) begin
         @(negedge i_clk);
      end
      if (!o_arready) begin
         abort_run("read request was not accepted in time");
      end
      @(posedge i_clk);
      i_arvalid <= 1'b0;
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output t_resp resp);
      int cnt;
      send_write(addr, data, strb);
      @(negedge i_clk);
      for (cnt = 0; !(o_bvalid && i_bready) && cnt < WAIT_MAX; cnt++) begin
         @(negedge i_clk);
      end
      if (!(o_bvalid && i_bready)) begin
         abort_run("write response did not arrive in time");
      end
      resp = o_bresp;
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [31:0] data,
                           output t_resp resp);
      int cnt;
      send_read(addr);
      @(negedge i_clk);
      for (cnt = 0; !(o_rvalid && i_rready) && cnt < WAIT_MAX; cnt++) begin
         @(negedge i_clk);
      end
      if (!(o_rvalid && i_rready)) begin
         abort_run("read data did not arrive in time");
      end
      data = o_rdata;
      resp = o_rresp;
   endtask

   task automatic reg_write(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] old_dir;
      t_resp       exp_r;
      t_resp       got_r;
      old_dir = model_dir;
      exp_r   = model_write(addr, data, strb);
      // Let go of pads the DUT may start driving before the response
      @(posedge i_clk);
      pad_en <= ~(old_dir | model_dir);
      bus_write(addr, data, strb, got_r);
      if (got_r !== exp_r) begin
         note_mismatch("o_bresp", got_r, exp_r);
      end
      @(posedge i_clk);
      pad_en <= ~model_dir;
   endtask

   task automatic check_read(input logic [15:0] addr);
      logic [31:0] exp_d;
      logic [31:0] got_d;
      t_resp       exp_r;
      t_resp       got_r;
      exp_r = model_read(addr, exp_d);
      bus_read(addr, got_d, got_r);
      if (got_r !== exp_r) begin
         note_mismatch("o_rresp", got_r, exp_r);
      end
      if (got_d !== exp_d) begin
         note_mismatch("o_rdata", got_d, exp_d);
      end
   endtask

`endif

// ==== verif/tb_io_bridge.sv ====
// Runs io_bridge_top at its default queue depth and 32 pads; undriven pads are pulled low
`timescale 1ns/1ns

module tb_io_bridge
   import bus_pkg::*;
   import soc_map_pkg::*;
();

   localparam int BURST_N    = 48;
   localparam int STALL_N    = 256;
   localparam int BURST_WAIT = 4000;

   logic              i_clk;
   logic              i_reset;
   logic              i_awvalid;
   logic              o_awready;
   logic [ADDR_W-1:0] i_awaddr;
   logic              i_wvalid;
   logic              o_wready;
   logic [DATA_W-1:0] i_wdata;
   logic [STRB_W-1:0] i_wstrb;
   logic              o_bvalid;
   logic              i_bready;
   t_resp             o_bresp;
   logic              i_arvalid;
   logic              o_arready;
   logic [ADDR_W-1:0] i_araddr;
   logic              o_rvalid;
   logic              i_rready;
   logic [DATA_W-1:0] o_rdata;
   t_resp             o_rresp;
   logic              o_irq;
   tri0  [31:0]       gpio_pads;
   logic [31:0]       pad_val;
   logic [31:0]       pad_en;

   int errors;
   int tests_run;
   int tests_failed;
   int test_err0;

   // Burst stimulus with its expected responses, in issue order
   logic        op_write [BURST_N];
   logic [15:0] op_addr  [BURST_N];
   logic [31:0] op_data  [BURST_N];
   logic [3:0]  op_strb  [BURST_N];
   t_resp       exp_resp [BURST_N];
   logic [31:0] exp_data [BURST_N];
   logic        stall_b  [STALL_N];
   logic        stall_r  [STALL_N];

   task automatic abort_run(input string why);
      $display("Run stopped: %s", why);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic note_mismatch(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
      errors++;
   endtask

   `include "tb_io_model.svh"

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   for (genvar g = 0; g < 32; g++) begin : g_pad_drv
      assign gpio_pads[g] = pad_en[g] ? pad_val[g] : 1'bz;
   end

   io_bridge_top u_io_bridge_top (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_awvalid (i_awvalid),
      .o_awready (o_awready),
      .i_awaddr  (i_awaddr),
      .i_wvalid  (i_wvalid),
      .o_wready  (o_wready),
      .i_wdata   (i_wdata),
      .i_wstrb   (i_wstrb),
      .o_bvalid  (o_bvalid),
      .i_bready  (i_bready),
      .o_bresp   (o_bresp),
      .i_arvalid (i_arvalid),
      .o_arready (o_arready),
      .i_araddr  (i_araddr),
      .o_rvalid  (o_rvalid),
      .i_rready  (i_rready),
      .o_rdata   (o_rdata),
      .o_rresp   (o_rresp),
      .io_gpio   (gpio_pads),
      .o_irq     (o_irq)
   );

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != test_err0) begin
         tests_failed++;
      end
      $display("Test %0d %s: %0d errors", tests_run, name, errors - test_err0);
      test_err0 = errors;
   endtask

   task automatic check_irq();
      @(negedge i_clk);
      if (o_irq !== |(model_stat & model_mask)) begin
         note_mismatch("o_irq", o_irq, |(model_stat & model_mask));
      end
   endtask

   // Random ready stalls; each response is checked against the next expected one
   task automatic collect_responses();
      int got;
      int cyc;
      got = 0;
      cyc = 0;
      while (got < BURST_N) begin
         if (cyc == BURST_WAIT) begin
            abort_run("burst responses did not all arrive in time");
         end
         @(posedge i_clk);
         i_bready <= stall_b[cyc % STALL_N];
         i_rready <= stall_r[cyc % STALL_N];
         @(negedge i_clk);
         if (o_bvalid && i_bready) begin
            if (!op_write[got]) begin
               $display("Write response came where read %0d was expected", got);
               errors++;
            end else if (o_bresp !== exp_resp[got]) begin
               note_mismatch("o_bresp", o_bresp, exp_resp[got]);
            end
            got++;
         end else if (o_rvalid && i_rready) begin
            if (op_write[got]) begin
               $display("Read data came where write %0d was expected", got);
               errors++;
            end else begin
               if (o_rresp !== exp_resp[got]) begin
                  note_mismatch("o_rresp", o_rresp, exp_resp[got]);
               end
               if (o_rdata !== exp_data[got]) begin
                  note_mismatch("o_rdata", o_rdata, exp_data[got]);
               end
            end
            got++;
         end
         cyc++;
      end
      @(posedge i_clk);
      i_bready <= 1'b1;
      i_rready <= 1'b1;
   endtask

   initial begin
      int          i;
      logic [31:0] r;
      logic [15:0] addr;
      logic [31:0] new_pads;

      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_err0    = 0;
      i_reset      = 1'b1;
      i_awvalid    = 1'b0;
      i_awaddr     = '0;
      i_wvalid     = 1'b0;
      i_wdata      = '0;
      i_wstrb      = '0;
      i_bready     = 1'b1;
      i_arvalid    = 1'b0;
      i_araddr     = '0;
      i_rready     = 1'b1;
      pad_val      = '0;
      pad_en       = '1;
      repeat (3) @(posedge i_clk);
      i_reset <= 1'b0;

      // ******************************
      // Reset state and ID
      // ******************************
      @(negedge i_clk);
      if (o_bvalid !== 1'b0) begin
         note_mismatch("o_bvalid", o_bvalid, 1'b0);
      end
      if (o_rvalid !== 1'b0) begin
         note_mismatch("o_rvalid", o_rvalid, 1'b0);
      end
      if (o_irq !== 1'b0) begin
         note_mismatch("o_irq", o_irq, 1'b0);
      end
      check_read(REG_OUT);
      check_read(REG_DIR);
      check_read(REG_IRQ_MASK);
      check_read(REG_IRQ_STAT);
      check_read(REG_ID);
      finish_test("reset state");

      for (i = 0; i < 40; i++) begin
         r    = rand_bits(2);
         addr = (r == 0) ? REG_OUT : (r == 1) ? REG_DIR : REG_IRQ_MASK;
         reg_write(addr, rand_bits(32), rand_bits(4));
         check_read(addr);
      end
      finish_test("strobed writes");

      for (i = 0; i < 8; i++) begin
         reg_write(REG_DIR, rand_bits(32), 4'hf);
         reg_write(REG_OUT, rand_bits(32), 4'hf);
         @(negedge i_clk);
         if ((gpio_pads & model_dir) !== (model_out & model_dir)) begin
            note_mismatch("io_gpio", gpio_pads & model_dir, model_out & model_dir);
         end
      end
      finish_test("pad drive");

      // ******************************
      // Inputs and edge interrupt
      // ******************************
      reg_write(REG_IRQ_MASK, rand_bits(32), 4'hf);
      @(posedge i_clk);
      pad_val <= rand_bits(32);
      repeat (4) @(posedge i_clk);
      reg_write(REG_IRQ_STAT, 32'hffff_ffff, 4'hf);
      check_read(REG_IN);
      check_read(REG_IRQ_STAT);
      for (i = 0; i < 6; i++) begin
         new_pads   = rand_bits(32);
         model_stat = model_stat | (new_pads & ~pad_val & ~model_dir);
         @(posedge i_clk);
         pad_val <= new_pads;
         repeat (4) @(posedge i_clk);
         check_read(REG_IN);
         check_read(REG_IRQ_STAT);
         check_irq();
         reg_write(REG_IRQ_STAT, rand_bits(32), 4'hf);
         check_read(REG_IRQ_STAT);
         check_irq();
      end
      finish_test("input and interrupt");

      for (i = 0; i < 10; i++) begin
         reg_write(unmapped_addr(), rand_bits(32), rand_bits(4));
         check_read(unmapped_addr());
      end
      check_read(REG_OUT);
      check_read(REG_DIR);
      check_read(REG_IRQ_MASK);
      finish_test("unmapped access");

      // ******************************
      // Burst under back-pressure
      // ******************************
      for (i = 0; i < BURST_N; i++) begin
         op_write[i] = rand_bits(1);
         r           = rand_bits(2);
         op_data[i]  = rand_bits(32);
         op_strb[i]  = rand_bits(4);
         if (r == 3) begin
            op_addr[i] = unmapped_addr();
         end else if (op_write[i]) begin
            op_addr[i] = r[0] ? REG_IRQ_MASK : REG_OUT;
         end else begin
            op_addr[i] = (r == 0) ? REG_OUT : (r == 1) ? REG_IRQ_MASK : REG_DIR;
         end
         if (op_write[i]) begin
            exp_resp[i] = model_write(op_addr[i], op_data[i], op_strb[i]);
            exp_data[i] = '0;
         end else begin
            exp_resp[i] = model_read(op_addr[i], exp_data[i]);
         end
      end
      for (i = 0; i < STALL_N; i++) begin
         stall_b[i] = rand_bits(1);
         stall_r[i] = rand_bits(1);
      end
      fork
         begin
            for (int k = 0; k < BURST_N; k++) begin
               if (op_write[k]) begin
                  send_write(op_addr[k], op_data[k], op_strb[k]);
               end else begin
                  send_read(op_addr[k]);
               end
            end
         end
         collect_responses();
      join
      for (i = 0; i < 8; i++) begin
         @(negedge i_clk);
         if (o_bvalid || o_rvalid) begin
            $display("Extra response seen after the burst at %0t ns", $time);
            errors++;
         end
      end
      finish_test("back-pressure and order");

      $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+verif
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/wb_if.sv
verilog/pipe_fifo.sv
verilog/axi_req_front.sv
verilog/wb_master.sv
verilog/gpio_regs.sv
verilog/axi_resp_back.sv
verilog/io_bridge_top.sv
verif/tb_io_bridge.sv

// ==== Bender.yml ====
package:
  name: io_bridge

sources:
  - verilog/bus_pkg.sv
  - verilog/soc_map_pkg.sv
  - verilog/wb_if.sv
  - verilog/pipe_fifo.sv
  - verilog/axi_req_front.sv
  - verilog/wb_master.sv
  - verilog/gpio_regs.sv
  - verilog/axi_resp_back.sv
  - verilog/io_bridge_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_io_bridge.sv
